//--- sim.f
rtl/l1d_pkg.sv
rtl/l1d_tag_store.sv
rtl/l1d_data_store.sv
rtl/l1d_victim_sel.sv
rtl/l1d_ctrl.sv
rtl/l1d_top.sv
verif/l1d_bus_mem.sv
verif/tb_l1d_top.sv

//--- Bender.yml
package:
  name: l1d_cache

sources:
  - rtl/l1d_pkg.sv
  - rtl/l1d_tag_store.sv
  - rtl/l1d_data_store.sv
  - rtl/l1d_victim_sel.sv
  - rtl/l1d_ctrl.sv
  - rtl/l1d_top.sv
  - target: simulation
    files:
      - verif/l1d_bus_mem.sv
      - verif/tb_l1d_top.sv

//--- verif/tb_l1d_top.sv
`timescale 1ns/1ps

module tb_l1d_top;

    typedef enum logic [1:0] {OP_RD, OP_WR, OP_RD_HOLD, OP_CHK_WB} op_e;

    localparam int NUM_ROWS       = 17;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * 200;

    logic            clk_i;
    logic            rstn_i;
    logic            req_valid_i;
    logic            req_write_i;
    logic            req_uncached_i;
    l1d_pkg::addr_t  req_addr_i;
    l1d_pkg::word_t  req_data_i;
    logic            req_ready_o;
    logic            resp_valid_o;
    l1d_pkg::word_t  resp_data_o;
    logic            resp_ready_i;
    logic            bus_req_valid_o;
    logic            bus_req_write_o;
    logic            bus_req_uncached_o;
    l1d_pkg::addr_t  bus_req_addr_o;
    l1d_pkg::block_t bus_req_block_o;
    logic            bus_req_ready_i;
    logic            bus_resp_valid_i;
    l1d_pkg::block_t bus_resp_block_i;
    logic            bus_resp_ready_o;

    // Stimulus table with one entry per row
    string           row_name  [NUM_ROWS];
    op_e             row_op    [NUM_ROWS];
    logic            row_unc   [NUM_ROWS];
    l1d_pkg::addr_t  row_addr  [NUM_ROWS];
    l1d_pkg::word_t  row_wdata [NUM_ROWS];
    l1d_pkg::word_t  row_exp   [NUM_ROWS];
    int unsigned     row_bus   [NUM_ROWS];
    int              rows_loaded = 0;

    // Current row as seen by the bus monitor
    string           cur_name = "reset";
    logic            cur_unc;
    logic            cur_write;
    l1d_pkg::addr_t  cur_addr;
    l1d_pkg::word_t  cur_wdata;

    int unsigned     bus_count   = 0;
    int unsigned     cycle_count = 0;
    l1d_pkg::addr_t  wb_addr;
    l1d_pkg::block_t wb_block;
    logic [15:0]     lfsr_q = 16'd21773;

    l1d_top u_dut (.*);

    l1d_bus_mem u_mem (
        .clk_i              (clk_i),
        .rstn_i             (rstn_i),
        .bus_req_valid_i    (bus_req_valid_o),
        .bus_req_write_i    (bus_req_write_o),
        .bus_req_uncached_i (bus_req_uncached_o),
        .bus_req_addr_i     (bus_req_addr_o),
        .bus_req_block_i    (bus_req_block_o),
        .bus_req_ready_o    (bus_req_ready_i),
        .bus_resp_valid_o   (bus_resp_valid_i),
        .bus_resp_block_o   (bus_resp_block_i),
        .bus_resp_ready_i   (bus_resp_ready_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    function automatic int unsigned rand_bits(input int unsigned n);
        int unsigned val;
        val = 0;
        for (int i = 0; i < n; i++) begin
            val    = (val << 1) | lfsr_q[0];
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
        end
        return val;
    endfunction

    // Memory content before any write
    function automatic l1d_pkg::word_t init_word(input l1d_pkg::addr_t addr);
        return {2'b00, addr[31:2]} ^ 32'hA5A5_0000;
    endfunction

    task automatic check_equal(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH %s (%s): expected %h, actual %h", cur_name, what,
                     expected, actual);
            $display("Test FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic add_row(input string name, input op_e op, input logic unc,
                           input l1d_pkg::addr_t addr, input l1d_pkg::word_t wdata,
                           input l1d_pkg::word_t exp, input int unsigned nbus);
        row_name[rows_loaded]  = name;
        row_op[rows_loaded]    = op;
        row_unc[rows_loaded]   = unc;
        row_addr[rows_loaded]  = addr;
        row_wdata[rows_loaded] = wdata;
        row_exp[rows_loaded]   = exp;
        row_bus[rows_loaded]   = nbus;
        rows_loaded++;
    endtask

    task automatic load_table();
        add_row("rd_miss",       OP_RD, 0, 32'h0000_1040, 0, init_word(32'h1040), 1);
        add_row("rd_same_block", OP_RD, 0, 32'h0000_1048, 0, init_word(32'h1048), 0);
        add_row("wr_hit",        OP_WR, 0, 32'h0000_1044, 32'hDEAD_BEEF, 0, 0);
        add_row("rd_written",    OP_RD, 0, 32'h0000_1044, 0, 32'hDEAD_BEEF, 0);
        add_row("rd_neighbor",   OP_RD, 0, 32'h0000_104C, 0, init_word(32'h104C), 0);
        // Set 5 fills all four ways before the round-robin pointer picks way 0
        add_row("wr_miss",       OP_WR, 0, 32'h0000_2054, 32'h1234_5678, 0, 1);
        add_row("fill_way1",     OP_RD, 0, 32'h0000_3054, 0, init_word(32'h3054), 1);
        add_row("fill_way2",     OP_RD, 0, 32'h0000_4054, 0, init_word(32'h4054), 1);
        add_row("fill_way3",     OP_RD, 0, 32'h0000_5054, 0, init_word(32'h5054), 1);
        add_row("evict_dirty",   OP_RD, 0, 32'h0000_6054, 0, init_word(32'h6054), 2);
        add_row("wb_contents",   OP_CHK_WB, 0, 32'h0000_2054, 32'h1234_5678, 0, 0);
        add_row("evict_clean",   OP_RD, 0, 32'h0000_7054, 0, init_word(32'h7054), 1);
        add_row("rd_refill",     OP_RD, 0, 32'h0000_2054, 0, 32'h1234_5678, 1);
        // Uncached rows share set and word with the dirty line at 0x1044
        add_row("unc_wr",        OP_WR, 1, 32'h8000_0144, 32'hCAFE_F00D, 0, 1);
        add_row("unc_rd",        OP_RD, 1, 32'h8000_0144, 0, 32'hCAFE_F00D, 1);
        add_row("rd_after_unc",  OP_RD, 0, 32'h0000_1044, 0, 32'hDEAD_BEEF, 0);
        add_row("rd_backpress",  OP_RD_HOLD, 0, 32'h0000_1048, 0, init_word(32'h1048), 0);
    endtask

    task automatic run_row(input int i);
        int unsigned    start_count;
        int unsigned    hold;
        cur_name    = row_name[i];
        cur_unc     = row_unc[i];
        cur_write   = (row_op[i] == OP_WR);
        cur_addr    = row_addr[i];
        cur_wdata   = row_wdata[i];
        start_count = bus_count;
        if (row_op[i] == OP_CHK_WB) begin
            check_equal("write-back address", {row_addr[i][31:4], 4'h0}, wb_addr);
            check_equal("write-back word", row_wdata[i],
                        wb_block[32 * row_addr[i][3:2] +: 32]);
        end else begin
            @(negedge clk_i);
            req_valid_i    = 1'b1;
            req_write_i    = cur_write;
            req_uncached_i = cur_unc;
            req_addr_i     = cur_addr;
            req_data_i     = cur_wdata;
            resp_ready_i   = (row_op[i] != OP_RD_HOLD);
            while (!req_ready_o) @(negedge clk_i);
            @(negedge clk_i);
            req_valid_i = 1'b0;
            if (cur_write) begin
                while (!req_ready_o) @(negedge clk_i);
            end else begin
                while (!resp_valid_o) @(negedge clk_i);
                check_equal("read data", row_exp[i], resp_data_o);
                if (row_op[i] == OP_RD_HOLD) begin
                    hold = 2 + rand_bits(3);
                    repeat (hold) begin
                        @(negedge clk_i);
                        check_equal("held valid", 1, resp_valid_o);
                        check_equal("held data", row_exp[i], resp_data_o);
                    end
                    resp_ready_i = 1'b1;
                    @(negedge clk_i);
                    check_equal("valid after consume", 0, resp_valid_o);
                end
            end
        end
        check_equal("bus request count", row_bus[i], bus_count - start_count);
    endtask

    // Every accepted bus request must match the current row
    always @(posedge clk_i) begin
        if (rstn_i && bus_req_valid_o && bus_req_ready_i) begin
            bus_count <= bus_count + 1;
            check_equal("bus uncached flag", cur_unc, bus_req_uncached_o);
            if (cur_unc) begin
                check_equal("bus address", cur_addr, bus_req_addr_o);
                check_equal("bus write flag", cur_write, bus_req_write_o);
                if (cur_write) begin
                    check_equal("bus write word", cur_wdata, bus_req_block_o[31:0]);
                end
            end else if (bus_req_write_o) begin
                check_equal("bus block offset", 0, bus_req_addr_o[3:0]);
                wb_addr  <= bus_req_addr_o;
                wb_block <= bus_req_block_o;
            end else begin
                check_equal("fill address", {cur_addr[31:4], 4'h0}, bus_req_addr_o);
            end
        end
    end

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test FAILED");
            $fatal(1, "timeout");
        end
    end

    initial begin
        rstn_i         = 1'b0;
        req_valid_i    = 1'b0;
        req_write_i    = 1'b0;
        req_uncached_i = 1'b0;
        req_addr_i     = '0;
        req_data_i     = '0;
        resp_ready_i   = 1'b1;
        load_table();
        repeat (8) @(negedge clk_i);
        rstn_i = 1'b1;
        @(negedge clk_i);
        cur_name = "after_reset";
        check_equal("req_ready_o", 1, req_ready_o);
        check_equal("resp_valid_o", 0, resp_valid_o);
        check_equal("bus_req_valid_o", 0, bus_req_valid_o);
        check_equal("bus_resp_ready_o", 0, bus_resp_ready_o);
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(i);
        end
        $display("Test OK");
        $finish;
    end

endmodule

//--- verif/l1d_bus_mem.sv
`timescale 1ns/1ps

module l1d_bus_mem (
    input  logic            clk_i,
    input  logic            rstn_i,
    input  logic            bus_req_valid_i,
    input  logic            bus_req_write_i,
    input  logic            bus_req_uncached_i,
    input  l1d_pkg::addr_t  bus_req_addr_i,
    input  l1d_pkg::block_t bus_req_block_i,
    output logic            bus_req_ready_o,
    output logic            bus_resp_valid_o,
    output l1d_pkg::block_t bus_resp_block_o,
    input  logic            bus_resp_ready_i
);

    localparam logic [15:0] LFSR_SEED = 16'd21773;

    // Backing store indexed by word address, only written words are kept
    l1d_pkg::word_t  mem [logic [29:0]];
    logic [15:0]     lfsr_q;
    logic            rd_pending;
    l1d_pkg::block_t rd_block;
    int unsigned     req_wait;
    int unsigned     resp_wait;

    function automatic int unsigned rand_bits(input int unsigned n);
        int unsigned val;
        val = 0;
        for (int i = 0; i < n; i++) begin
            val    = (val << 1) | lfsr_q[0];
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
        end
        return val;
    endfunction

    function automatic l1d_pkg::word_t word_at(input logic [29:0] w);
        return mem.exists(w) ? mem[w] : ({2'b00, w} ^ 32'hA5A5_0000);
    endfunction

    // Bus side starts idle
    initial begin
        bus_req_ready_o  <= 1'b0;
        bus_resp_valid_o <= 1'b0;
        bus_resp_block_o <= '0;
    end

    always @(posedge clk_i) begin
        if (!rstn_i) begin
            rd_pending <= 1'b0;
        end else if (bus_req_valid_i && bus_req_ready_o) begin
            if (bus_req_write_i && bus_req_uncached_i) begin
                mem[bus_req_addr_i[31:2]] = bus_req_block_i[31:0];
            end else if (bus_req_write_i) begin
                for (int w = 0; w < 4; w++) begin
                    mem[{bus_req_addr_i[31:4], 2'(w)}] = bus_req_block_i[32*w +: 32];
                end
            end else begin
                rd_pending <= 1'b1;
                rd_block   <= '0;
                if (bus_req_uncached_i) begin
                    rd_block[31:0] <= word_at(bus_req_addr_i[31:2]);
                end else begin
                    for (int w = 0; w < 4; w++) begin
                        rd_block[32*w +: 32] <= word_at({bus_req_addr_i[31:4], 2'(w)});
                    end
                end
            end
        end else if (bus_resp_valid_o && bus_resp_ready_i) begin
            rd_pending <= 1'b0;
        end
    end

    always @(negedge clk_i) begin
        if (!rstn_i) begin
            lfsr_q = LFSR_SEED;
            req_wait = 0;
            resp_wait = 0;
            bus_req_ready_o  <= 1'b0;
            bus_resp_valid_o <= 1'b0;
            bus_resp_block_o <= '0;
        end else begin
            // Ready lasts one cycle since the cache holds valid until taken
            if (bus_req_ready_o) begin
                bus_req_ready_o <= 1'b0;
                req_wait = rand_bits(2);
            end else if (bus_req_valid_i) begin
                if (req_wait == 0) begin
                    bus_req_ready_o <= 1'b1;
                end else begin
                    req_wait--;
                end
            end
            if (!rd_pending) begin
                bus_resp_valid_o <= 1'b0;
            end else if (!bus_resp_valid_o) begin
                if (resp_wait == 0) begin
                    bus_resp_valid_o <= 1'b1;
                    bus_resp_block_o <= rd_block;
                    resp_wait = rand_bits(2);
                end else begin
                    resp_wait--;
                end
            end
        end
    end

endmodule

//--- rtl/l1d_top.sv
`timescale 1ns/1ps

module l1d_top (
    input  logic            clk_i,
    input  logic            rstn_i,
    input  logic            req_valid_i,
    input  logic            req_write_i,
    input  logic            req_uncached_i,
    input  l1d_pkg::addr_t  req_addr_i,
    input  l1d_pkg::word_t  req_data_i,
    output logic            req_ready_o,
    output logic            resp_valid_o,
    output l1d_pkg::word_t  resp_data_o,
    input  logic            resp_ready_i,
    output logic            bus_req_valid_o,
    output logic            bus_req_write_o,
    output logic            bus_req_uncached_o,
    output l1d_pkg::addr_t  bus_req_addr_o,
    output l1d_pkg::block_t bus_req_block_o,
    input  logic            bus_req_ready_i,
    input  logic            bus_resp_valid_i,
    input  l1d_pkg::block_t bus_resp_block_i,
    output logic            bus_resp_ready_o
);

    l1d_pkg::set_idx_t  set;
    l1d_pkg::tag_t      tag;
    l1d_pkg::word_sel_t word_sel;
    l1d_pkg::way_mask_t valid;
    logic               hit;
    l1d_pkg::way_idx_t  hit_way;
    l1d_pkg::way_idx_t  victim_way;
    logic               victim_dirty;
    l1d_pkg::tag_t      victim_tag;
    l1d_pkg::word_t     rd_word;
    l1d_pkg::block_t    rd_block;
    logic               mark_dirty;
    logic               wr_word;
    logic               fill;
    l1d_pkg::way_idx_t  fill_way;
    logic               advance;

    l1d_ctrl u_ctrl (
        .clk_i, .rstn_i,
        .req_valid_i, .req_write_i, .req_uncached_i, .req_addr_i, .req_data_i, .req_ready_o,
        .resp_valid_o, .resp_data_o, .resp_ready_i,
        .bus_req_valid_o, .bus_req_write_o, .bus_req_uncached_o, .bus_req_addr_o,
        .bus_req_block_o, .bus_req_ready_i,
        .bus_resp_valid_i, .bus_resp_block_i, .bus_resp_ready_o,
        .set_o          (set),
        .tag_o          (tag),
        .word_sel_o     (word_sel),
        .hit_i          (hit),
        .hit_way_i      (hit_way),
        .victim_way_i   (victim_way),
        .victim_dirty_i (victim_dirty),
        .victim_tag_i   (victim_tag),
        .rd_word_i      (rd_word),
        .rd_block_i     (rd_block),
        .valid_all_i    (&valid),
        .mark_dirty_o   (mark_dirty),
        .wr_word_o      (wr_word),
        .fill_o         (fill),
        .fill_way_o     (fill_way),
        .advance_o      (advance)
    );

    l1d_tag_store u_tag_store (
        .clk_i, .rstn_i,
        .set_i          (set),
        .tag_i          (tag),
        .mark_dirty_i   (mark_dirty),
        .dirty_way_i    (fill_way),
        .fill_i         (fill),
        .fill_way_i     (fill_way),
        .valid_o        (valid),
        .hit_o          (hit),
        .hit_way_o      (hit_way),
        .victim_way_i   (victim_way),
        .victim_dirty_o (victim_dirty),
        .victim_tag_o   (victim_tag)
    );

    // Write word is staged in the low word of the bus block outside write-back
    l1d_data_store u_data_store (
        .clk_i,
        .set_i          (set),
        .way_i          (fill_way),
        .word_sel_i     (word_sel),
        .wr_word_i      (wr_word),
        .wr_data_i      (bus_req_block_o[l1d_pkg::WORD_W-1:0]),
        .fill_i         (fill),
        .fill_block_i   (bus_resp_block_i),
        .rd_word_o      (rd_word),
        .rd_block_o     (rd_block)
    );

    l1d_victim_sel u_victim_sel (
        .clk_i, .rstn_i,
        .valid_i        (valid),
        .advance_i      (advance),
        .victim_way_o   (victim_way)
    );

endmodule

//--- rtl/l1d_ctrl.sv
`timescale 1ns/1ps

module l1d_ctrl (
    input  logic               clk_i,
    input  logic               rstn_i,
    input  logic               req_valid_i,
    input  logic               req_write_i,
    input  logic               req_uncached_i,
    input  l1d_pkg::addr_t     req_addr_i,
    input  l1d_pkg::word_t     req_data_i,
    output logic               req_ready_o,
    output logic               resp_valid_o,
    output l1d_pkg::word_t     resp_data_o,
    input  logic               resp_ready_i,
    output logic               bus_req_valid_o,
    output logic               bus_req_write_o,
    output logic               bus_req_uncached_o,
    output l1d_pkg::addr_t     bus_req_addr_o,
    output l1d_pkg::block_t    bus_req_block_o,
    input  logic               bus_req_ready_i,
    input  logic               bus_resp_valid_i,
    input  l1d_pkg::block_t    bus_resp_block_i,
    output logic               bus_resp_ready_o,
    output l1d_pkg::set_idx_t  set_o,
    output l1d_pkg::tag_t      tag_o,
    output l1d_pkg::word_sel_t word_sel_o,
    input  logic               hit_i,
    input  l1d_pkg::way_idx_t  hit_way_i,
    input  l1d_pkg::way_idx_t  victim_way_i,
    input  logic               victim_dirty_i,
    input  l1d_pkg::tag_t      victim_tag_i,
    input  l1d_pkg::word_t     rd_word_i,
    input  l1d_pkg::block_t    rd_block_i,
    input  logic               valid_all_i,
    output logic               mark_dirty_o,
    output logic               wr_word_o,
    output logic               fill_o,
    output l1d_pkg::way_idx_t  fill_way_o,
    output logic               advance_o
);

    l1d_pkg::ctrl_state_e state_q, state_d;
    l1d_pkg::addr_t       addr_q;
    l1d_pkg::word_t       data_q;
    logic                 write_q;
    l1d_pkg::way_idx_t    way_q;
    l1d_pkg::addr_t       wb_addr_q;
    l1d_pkg::block_t      wb_block_q;
    logic                 resp_valid_q;
    l1d_pkg::word_t       resp_data_q;
    logic                 resp_load;

    assign word_sel_o = addr_q[l1d_pkg::BYTE_OFS_W +: l1d_pkg::WORD_SEL_W];
    assign set_o = addr_q[l1d_pkg::BYTE_OFS_W + l1d_pkg::WORD_SEL_W +: l1d_pkg::SET_IDX_W];
    assign tag_o = addr_q[l1d_pkg::ADDR_W-1 -: l1d_pkg::TAG_W];

    assign req_ready_o  = (state_q == l1d_pkg::IDLE);
    assign resp_valid_o = resp_valid_q;
    assign resp_data_o  = resp_data_q;

    // Bus fields come from registers that hold still in the request states
    assign bus_req_valid_o    = state_q inside {l1d_pkg::WB_REQ, l1d_pkg::FILL_REQ,
                                                l1d_pkg::UNC_REQ};
    assign bus_req_write_o    = (state_q == l1d_pkg::WB_REQ) ||
                                (state_q == l1d_pkg::UNC_REQ && write_q);
    assign bus_req_uncached_o = (state_q == l1d_pkg::UNC_REQ);
    assign bus_req_addr_o     = (state_q == l1d_pkg::WB_REQ)  ? wb_addr_q :
                                (state_q == l1d_pkg::UNC_REQ) ? addr_q :
                                {tag_o, set_o, {(l1d_pkg::WORD_SEL_W + l1d_pkg::BYTE_OFS_W){1'b0}}};
    assign bus_req_block_o    = (state_q == l1d_pkg::WB_REQ) ? wb_block_q :
                                {{(l1d_pkg::BLOCK_W - l1d_pkg::WORD_W){1'b0}}, data_q};
    assign bus_resp_ready_o   = state_q inside {l1d_pkg::FILL_WAIT, l1d_pkg::UNC_WAIT};

    // Store strobes
    assign mark_dirty_o = (state_q == l1d_pkg::RESP) && write_q;
    assign wr_word_o    = mark_dirty_o;
    assign fill_o       = (state_q == l1d_pkg::FILL_WAIT) && bus_resp_valid_i;
    assign advance_o    = (state_q == l1d_pkg::LOOKUP) && !hit_i && valid_all_i;
    assign fill_way_o   = (state_q != l1d_pkg::LOOKUP) ? way_q :
                          hit_i ? hit_way_i : victim_way_i;

    // Cached read response is picked from the hit way on the first RESP cycle
    assign resp_load = (state_q == l1d_pkg::RESP) && !write_q && !resp_valid_q;

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            l1d_pkg::IDLE: begin
                if (req_valid_i) begin
                    state_d = req_uncached_i ? l1d_pkg::UNC_REQ : l1d_pkg::LOOKUP;
                end
            end
            l1d_pkg::LOOKUP: begin
                if (hit_i) begin
                    state_d = l1d_pkg::RESP;
                end else if (victim_dirty_i) begin
                    state_d = l1d_pkg::WB_REQ;
                end else begin
                    state_d = l1d_pkg::FILL_REQ;
                end
            end
            l1d_pkg::WB_REQ: begin
                if (bus_req_ready_i) state_d = l1d_pkg::FILL_REQ;
            end
            l1d_pkg::FILL_REQ: begin
                if (bus_req_ready_i) state_d = l1d_pkg::FILL_WAIT;
            end
            // Look up again after the fill, which now hits
            l1d_pkg::FILL_WAIT: begin
                if (bus_resp_valid_i) state_d = l1d_pkg::LOOKUP;
            end
            l1d_pkg::UNC_REQ: begin
                if (bus_req_ready_i) state_d = write_q ? l1d_pkg::IDLE : l1d_pkg::UNC_WAIT;
            end
            l1d_pkg::UNC_WAIT: begin
                if (bus_resp_valid_i) state_d = l1d_pkg::RESP;
            end
            l1d_pkg::RESP: begin
                if (write_q || (resp_valid_q && resp_ready_i)) state_d = l1d_pkg::IDLE;
            end
            default: state_d = l1d_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q      <= l1d_pkg::IDLE;
            resp_valid_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if ((state_q == l1d_pkg::UNC_WAIT && bus_resp_valid_i) || resp_load) begin
                resp_valid_q <= 1'b1;
            end else if (resp_valid_q && resp_ready_i) begin
                resp_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_valid_i && req_ready_o) begin
            addr_q  <= req_addr_i;
            data_q  <= req_data_i;
            write_q <= req_write_i;
        end
        if (state_q == l1d_pkg::LOOKUP) begin
            way_q      <= fill_way_o;
            wb_addr_q  <= {victim_tag_i, set_o,
                           {(l1d_pkg::WORD_SEL_W + l1d_pkg::BYTE_OFS_W){1'b0}}};
            wb_block_q <= rd_block_i;
        end
        if (state_q == l1d_pkg::UNC_WAIT && bus_resp_valid_i) begin
            resp_data_q <= bus_resp_block_i[l1d_pkg::WORD_W-1:0];
        end else if (resp_load) begin
            resp_data_q <= rd_word_i;
        end
    end

    assert property (@(posedge clk_i) disable iff (!rstn_i)
        bus_req_valid_o && !bus_req_ready_i |=> bus_req_valid_o && $stable(bus_req_write_o)
            && $stable(bus_req_addr_o) && $stable(bus_req_block_o));

    assert property (@(posedge clk_i) disable iff (!rstn_i)
        resp_valid_o && !resp_ready_i |=> resp_valid_o && $stable(resp_data_o));

endmodule

//--- rtl/l1d_victim_sel.sv
`timescale 1ns/1ps

module l1d_victim_sel (
    input  logic               clk_i,
    input  logic               rstn_i,
    input  l1d_pkg::way_mask_t valid_i,
    input  logic               advance_i,
    output l1d_pkg::way_idx_t  victim_way_o
);

    l1d_pkg::way_idx_t rr_q;

    // Round-robin pointer only moves when a full set loses a line
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            rr_q <= '0;
        end else if (advance_i) begin
            rr_q <= l1d_pkg::way_idx_t'((rr_q + 1) % l1d_pkg::NUM_WAYS);
        end
    end

    // Lowest invalid way wins over the pointer
    always_comb begin
        victim_way_o = rr_q;
        for (int w = l1d_pkg::NUM_WAYS - 1; w >= 0; w--) begin
            if (!valid_i[w]) begin
                victim_way_o = l1d_pkg::way_idx_t'(w);
            end
        end
    end

endmodule

//--- rtl/l1d_data_store.sv
`timescale 1ns/1ps

module l1d_data_store (
    input  logic               clk_i,
    input  l1d_pkg::set_idx_t  set_i,
    input  l1d_pkg::way_idx_t  way_i,
    input  l1d_pkg::word_sel_t word_sel_i,
    input  logic               wr_word_i,
    input  l1d_pkg::word_t     wr_data_i,
    input  logic               fill_i,
    input  l1d_pkg::block_t    fill_block_i,
    output l1d_pkg::word_t     rd_word_o,
    output l1d_pkg::block_t    rd_block_o
);

    l1d_pkg::block_t blocks_q [l1d_pkg::NUM_SETS][l1d_pkg::NUM_WAYS];

    assign rd_block_o = blocks_q[set_i][way_i];
    assign rd_word_o  = rd_block_o[word_sel_i * l1d_pkg::WORD_W +: l1d_pkg::WORD_W];

    always_ff @(posedge clk_i) begin
        if (fill_i) begin
            blocks_q[set_i][way_i] <= fill_block_i;
        end else if (wr_word_i) begin
            // Full aligned word without byte masks
            blocks_q[set_i][way_i][word_sel_i * l1d_pkg::WORD_W +: l1d_pkg::WORD_W] <= wr_data_i;
        end
    end

    // Controller never writes a word while a refill lands
    assert property (@(posedge clk_i) !(wr_word_i && fill_i));

endmodule

//--- rtl/l1d_tag_store.sv
`timescale 1ns/1ps

module l1d_tag_store (
    input  logic               clk_i,
    input  logic               rstn_i,
    input  l1d_pkg::set_idx_t  set_i,
    input  l1d_pkg::tag_t      tag_i,
    input  logic               mark_dirty_i,
    input  l1d_pkg::way_idx_t  dirty_way_i,
    input  logic               fill_i,
    input  l1d_pkg::way_idx_t  fill_way_i,
    output l1d_pkg::way_mask_t valid_o,
    output logic               hit_o,
    output l1d_pkg::way_idx_t  hit_way_o,
    input  l1d_pkg::way_idx_t  victim_way_i,
    output logic               victim_dirty_o,
    output l1d_pkg::tag_t      victim_tag_o
);

    l1d_pkg::tag_t      tags_q  [l1d_pkg::NUM_SETS][l1d_pkg::NUM_WAYS];
    l1d_pkg::way_mask_t valid_q [l1d_pkg::NUM_SETS];
    l1d_pkg::way_mask_t dirty_q [l1d_pkg::NUM_SETS];
    l1d_pkg::way_mask_t hit_vec;

    assign valid_o        = valid_q[set_i];
    assign victim_dirty_o = dirty_q[set_i][victim_way_i];
    assign victim_tag_o   = tags_q[set_i][victim_way_i];

    // Compare all ways of the indexed set
    always_comb begin
        hit_o     = 1'b0;
        hit_way_o = '0;
        for (int w = 0; w < l1d_pkg::NUM_WAYS; w++) begin
            hit_vec[w] = valid_q[set_i][w] && (tags_q[set_i][w] == tag_i);
            if (hit_vec[w]) begin
                hit_o     = 1'b1;
                hit_way_o = l1d_pkg::way_idx_t'(w);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            for (int s = 0; s < l1d_pkg::NUM_SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end else begin
            // A fill installs a clean line
            if (fill_i) begin
                valid_q[set_i][fill_way_i] <= 1'b1;
                dirty_q[set_i][fill_way_i] <= 1'b0;
            end
            if (mark_dirty_i) begin
                dirty_q[set_i][dirty_way_i] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (fill_i) begin
            tags_q[set_i][fill_way_i] <= tag_i;
        end
    end

    // Fills only follow a miss, so a tag never lives in two ways of a set
    assert property (@(posedge clk_i) disable iff (!rstn_i) $onehot0(hit_vec));

endmodule

//--- rtl/l1d_pkg.sv
package l1d_pkg;

    // Cache geometry
    localparam int ADDR_W     = 32;
    localparam int WORD_W     = 32;
    localparam int BLOCK_W    = 128;
    localparam int NUM_WAYS   = 4;
    localparam int NUM_SETS   = 16;

    // Address fields, low to high
    localparam int BYTE_OFS_W = 2;
    localparam int WORD_SEL_W = 2;
    localparam int SET_IDX_W  = 4;
    localparam int TAG_W      = ADDR_W - SET_IDX_W - WORD_SEL_W - BYTE_OFS_W;

    typedef logic [ADDR_W-1:0]     addr_t;
    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [BLOCK_W-1:0]    block_t;
    typedef logic [TAG_W-1:0]      tag_t;
    typedef logic [SET_IDX_W-1:0]  set_idx_t;
    typedef logic [1:0]            way_idx_t;
    typedef logic [NUM_WAYS-1:0]   way_mask_t;
    typedef logic [WORD_SEL_W-1:0] word_sel_t;

    // Controller states
    typedef enum logic [3:0] {
        IDLE,
        LOOKUP,
        WB_REQ,
        FILL_REQ,
        FILL_WAIT,
        UNC_REQ,
        UNC_WAIT,
        RESP
    } ctrl_state_e;

endpackage
